// File: test/piloop_testdata.txt
// err_i err_q ff_i ff_q kp_i kp_q ki_over_kp shift fb_en gate reset  exp_pi_out_i exp_pi_out_q
// All hex; expected pair is the output seven cycles after its line
01388 7F448 003E8 1F830 04000 00000 08000 2 0 0 1  003E8 3F830
01388 7F448 003E8 1F830 04000 00000 08000 2 0 0 1  003E8 3F830
01388 7F448 003E8 1F830 04000 00000 08000 2 0 0 1  003E8 3F830
01388 7F448 003E8 1F830 04000 00000 08000 2 0 0 1  003E8 3F830
003E8 7FE0C 003E8 1F830 04000 00000 08000 2 1 0 1  003E8 3FE0C
003E8 7FE0C 003E8 1F830 04000 00000 08000 2 1 0 1  003E8 3FE0C
003E8 7FE0C 003E8 1F830 04000 04000 08000 2 1 0 1  005DC 001F4
003E8 7FE0C 003E8 1F830 04000 04000 08000 2 1 0 1  005DC 001F4
186A0 7B1E0 003E8 1F830 04000 00000 08000 2 1 0 1  01FFF 3E000
186A0 7B1E0 00000 00000 04000 00000 08000 2 1 0 1  01FFF 3E000
67960 67960 00000 00000 1FFFF 20000 08000 2 1 0 1  20000 003E8
67960 67960 00000 00000 20000 20000 08000 2 1 0 1  3FC18 1FFFF
00500 7FD80 00000 00000 04000 00000 08000 2 1 0 1  005D2 3FDDF
00500 7FD80 00000 00000 04000 00000 08000 2 1 0 1  005DC 3FDDA
00500 7FD80 00000 00000 04000 00000 08000 2 1 0 1  005E6 3FDD5
00500 7FD80 1FC18 003E8 04000 00000 08000 2 1 1 0  005F0 3FDD0
00500 7FD80 1FC18 003E8 04000 00000 08000 2 1 1 0  005FA 3FDCB
00500 7FD80 000C8 00064 04000 00000 08000 2 1 1 0  005FA 3FDCB
00500 7FD80 000C8 00064 04000 00000 08000 2 1 1 0  005FA 3FDCB
00500 7FD80 000C8 00064 04000 00000 08000 2 1 1 0  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 0  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 0  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 1  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 0  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 0  005C8 3FDE4
00500 7FD80 000C8 00064 04000 00000 08000 2 1 0 0  005C8 3FDE4

// File: flist.f
design/piloop_pkg.sv
design/cplx_prop_gain.sv
design/integ_rail.sv
design/pi_combine.sv
design/piloop_top.sv
test/piloop_tb.sv

// File: Bender.yml
package:
  name: piloop

sources:
  - design/piloop_pkg.sv
  - design/cplx_prop_gain.sv
  - design/integ_rail.sv
  - design/pi_combine.sv
  - design/piloop_top.sv
  - target: test
    files:
      - test/piloop_tb.sv

// File: test/piloop_tb.sv
// Run from the project root; reads test/piloop_testdata.txt and holds inputs after the last line
`timescale 1ns/100ps

module piloop_tb;
	import piloop_pkg::*;

	// Error sample to matching output
	localparam int LAT = PROP_LAT + INT_LAT + OUT_LAT;
	localparam int MAX_VEC = 64;

	logic                     clk;
	logic                     arst_n;
	logic signed [ERR_W-1:0]  err_i, err_q;
	logic signed [FF_W-1:0]   fdfwd_i, fdfwd_q;
	logic signed [GAIN_W-1:0] kp_i, kp_q, ki_over_kp;
	logic [SHIFT_W-1:0]       post_mult_shift;
	logic                     feedback_enable, integrator_gate, integrator_reset;
	logic signed [DATA_W-1:0] pi_out_i, pi_out_q;

	// Vector table, one entry per data line
	logic signed [ERR_W-1:0]  v_err_i [MAX_VEC], v_err_q [MAX_VEC];
	logic signed [FF_W-1:0]   v_ff_i [MAX_VEC], v_ff_q [MAX_VEC];
	logic signed [GAIN_W-1:0] v_kp_i [MAX_VEC], v_kp_q [MAX_VEC], v_ratio [MAX_VEC];
	logic [SHIFT_W-1:0]       v_shift [MAX_VEC];
	logic                     v_fb_en [MAX_VEC], v_gate [MAX_VEC], v_clear [MAX_VEC];
	logic signed [DATA_W-1:0] v_exp_i [MAX_VEC], v_exp_q [MAX_VEC];

	// Expected outputs still in flight through the pipeline
	logic signed [DATA_W-1:0] exp_i_fifo [$];
	logic signed [DATA_W-1:0] exp_q_fifo [$];

	int n_vec = 0;
	int cycles = 0;
	int cycle_limit = 20;

	piloop_top UUT (
		.clk                (clk),
		.arst_n_i           (arst_n),
		.err_i_i            (err_i),
		.err_q_i            (err_q),
		.fdfwd_i_i          (fdfwd_i),
		.fdfwd_q_i          (fdfwd_q),
		.kp_i_i             (kp_i),
		.kp_q_i             (kp_q),
		.ki_over_kp_i       (ki_over_kp),
		.post_mult_shift_i  (post_mult_shift),
		.feedback_enable_i  (feedback_enable),
		.integrator_gate_i  (integrator_gate),
		.integrator_reset_i (integrator_reset),
		.pi_out_i_o         (pi_out_i),
		.pi_out_q_o         (pi_out_q)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_and_stop();
		$display("test failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_out(input string name, input logic signed [DATA_W-1:0] got,
			input logic signed [DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			fail_and_stop();
		end
	endtask

	task automatic load_vectors();
		int    fd;
		int    rc;
		string line;
		fd = $fopen("test/piloop_testdata.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the data file test/piloop_testdata.txt");
			fail_and_stop();
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			// Blank and comment lines hold no vector
			if (rc > 1 && line.substr(0, 1) != "//") begin
				if (n_vec >= MAX_VEC) begin
					$display("The data file holds more than %0d vectors", MAX_VEC);
					fail_and_stop();
				end
				rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					v_err_i[n_vec], v_err_q[n_vec], v_ff_i[n_vec], v_ff_q[n_vec],
					v_kp_i[n_vec], v_kp_q[n_vec], v_ratio[n_vec], v_shift[n_vec],
					v_fb_en[n_vec], v_gate[n_vec], v_clear[n_vec],
					v_exp_i[n_vec], v_exp_q[n_vec]);
				if (rc != 13) begin
					$display("Data file line does not hold 13 fields: %s", line);
					fail_and_stop();
				end
				n_vec++;
			end
		end
		$fclose(fd);
		if (n_vec == 0) begin
			$display("The data file holds no vectors");
			fail_and_stop();
		end
	endtask

	task automatic drive_idle();
		err_i            = '0;
		err_q            = '0;
		fdfwd_i          = '0;
		fdfwd_q          = '0;
		kp_i             = '0;
		kp_q             = '0;
		ki_over_kp       = '0;
		post_mult_shift  = '0;
		feedback_enable  = 1'b0;
		integrator_gate  = 1'b0;
		integrator_reset = 1'b0;
	endtask

	// Apply one line and queue its expected output
	task automatic drive_vector(input int k);
		err_i            = v_err_i[k];
		err_q            = v_err_q[k];
		fdfwd_i          = v_ff_i[k];
		fdfwd_q          = v_ff_q[k];
		kp_i             = v_kp_i[k];
		kp_q             = v_kp_q[k];
		ki_over_kp       = v_ratio[k];
		post_mult_shift  = v_shift[k];
		feedback_enable  = v_fb_en[k];
		integrator_gate  = v_gate[k];
		integrator_reset = v_clear[k];
		exp_i_fifo.push_back(v_exp_i[k]);
		exp_q_fifo.push_back(v_exp_q[k]);
	endtask

	// Run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: run still busy after %0d clock cycles", cycles);
			fail_and_stop();
		end
	end

	initial begin : main
		int                       k;
		logic signed [DATA_W-1:0] want_i, want_q;
		drive_idle();
		arst_n = 1'b0;
		load_vectors();
		cycle_limit = n_vec + 20;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		// Outputs are stable at the falling edge, checked before new inputs go on
		for (int c = 0; c < n_vec + LAT; c++) begin
			@(negedge clk);
			if (c >= LAT) begin
				k = c - LAT;
				want_i = exp_i_fifo.pop_front();
				want_q = exp_q_fifo.pop_front();
				check_out($sformatf("pi_out_i_o vector %0d", k), pi_out_i, want_i);
				check_out($sformatf("pi_out_q_o vector %0d", k), pi_out_q, want_q);
			end
			if (c < n_vec)
				drive_vector(c);
		end
		$display("test passed");
		$finish;
	end

endmodule

// File: design/piloop_top.sv
// Complex PI loop top; one clock at the ADC rate, seven cycles from error to output
`timescale 1ns/100ps

module piloop_top (
	input  logic                                   clk,
	input  logic                                   arst_n_i,
	// Complex error, setpoint already removed
	input  logic signed [piloop_pkg::ERR_W-1:0]    err_i_i,
	input  logic signed [piloop_pkg::ERR_W-1:0]    err_q_i,
	// Feedforward per rail
	input  logic signed [piloop_pkg::FF_W-1:0]     fdfwd_i_i,
	input  logic signed [piloop_pkg::FF_W-1:0]     fdfwd_q_i,
	// Loop gains
	input  logic signed [piloop_pkg::GAIN_W-1:0]   kp_i_i,
	input  logic signed [piloop_pkg::GAIN_W-1:0]   kp_q_i,
	input  logic signed [piloop_pkg::GAIN_W-1:0]   ki_over_kp_i,
	input  logic        [piloop_pkg::SHIFT_W-1:0]  post_mult_shift_i,
	// Level controls
	input  logic                                   feedback_enable_i,
	input  logic                                   integrator_gate_i,
	input  logic                                   integrator_reset_i,
	output logic signed [piloop_pkg::DATA_W-1:0]   pi_out_i_o,
	output logic signed [piloop_pkg::DATA_W-1:0]   pi_out_q_o
);
	import piloop_pkg::*;

	// Gated proportional term
	logic signed [DATA_W-1:0] prop_i, prop_q;
	// Integrator plus feedforward, fraction bits still attached
	logic signed [ACC_W-1:0]  integ_i, integ_q;

	cplx_prop_gain u_prop (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.err_i_i  (err_i_i),
		.err_q_i  (err_q_i),
		.kp_i_i   (kp_i_i),
		.kp_q_i   (kp_q_i),
		.fb_en_i  (feedback_enable_i),
		.prop_i_o (prop_i),
		.prop_q_o (prop_q)
	);

	// Both rails share the ratio, shift and controls
	integ_rail u_rail_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.sig_i    (prop_i),
		.ratio_i  (ki_over_kp_i),
		.shift_i  (post_mult_shift_i),
		.ff_i     (fdfwd_i_i),
		.gate_i   (integrator_gate_i),
		.clear_i  (integrator_reset_i),
		.acc_o    (integ_i)
	);

	integ_rail u_rail_q (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.sig_i    (prop_q),
		.ratio_i  (ki_over_kp_i),
		.shift_i  (post_mult_shift_i),
		.ff_i     (fdfwd_q_i),
		.gate_i   (integrator_gate_i),
		.clear_i  (integrator_reset_i),
		.acc_o    (integ_q)
	);

	pi_combine u_comb (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.prop_i_i  (prop_i),
		.prop_q_i  (prop_q),
		.integ_i_i (integ_i),
		.integ_q_i (integ_q),
		.pi_i_o    (pi_out_i_o),
		.pi_q_o    (pi_out_q_o)
	);

endmodule

// File: design/pi_combine.sv
// Adds the delayed proportional term to the integrator; assumes a two-cycle integrator rail
`timescale 1ns/100ps

module pi_combine (
	input  logic                                   clk,
	input  logic                                   arst_n_i,
	input  logic signed [piloop_pkg::DATA_W-1:0]   prop_i_i,
	input  logic signed [piloop_pkg::DATA_W-1:0]   prop_q_i,
	input  logic signed [piloop_pkg::ACC_W-1:0]    integ_i_i,
	input  logic signed [piloop_pkg::ACC_W-1:0]    integ_q_i,
	output logic signed [piloop_pkg::DATA_W-1:0]   pi_i_o,
	output logic signed [piloop_pkg::DATA_W-1:0]   pi_q_o
);
	import piloop_pkg::*;

	// Delay line matching the rail depth
	logic signed [DATA_W-1:0] prop_i_d1, prop_i_d2;
	logic signed [DATA_W-1:0] prop_q_d1, prop_q_d2;
	// Stage 1 sums with one guard bit
	logic signed [DATA_W:0]   sum_i_q, sum_q_q;

	// Rail when the guard bit and the sign disagree
	function automatic logic signed [DATA_W-1:0] sat_out(input logic signed [DATA_W:0] s);
		if (s[DATA_W] == s[DATA_W-1])
			return s[DATA_W-1:0];
		return {s[DATA_W], {(DATA_W-1){~s[DATA_W]}}};
	endfunction

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prop_i_d1 <= '0;
			prop_i_d2 <= '0;
			prop_q_d1 <= '0;
			prop_q_d2 <= '0;
			sum_i_q   <= '0;
			sum_q_q   <= '0;
			pi_i_o    <= '0;
			pi_q_o    <= '0;
		end else begin
			prop_i_d1 <= prop_i_i;
			prop_i_d2 <= prop_i_d1;
			prop_q_d1 <= prop_q_i;
			prop_q_d2 <= prop_q_d1;
			// Integrator fraction bits are dropped here
			sum_i_q <= (DATA_W+1)'($signed(integ_i_i[ACC_W-1:INT_DROP]))
				+ (DATA_W+1)'(prop_i_d2);
			sum_q_q <= (DATA_W+1)'($signed(integ_q_i[ACC_W-1:INT_DROP]))
				+ (DATA_W+1)'(prop_q_d2);
			pi_i_o  <= sat_out(sum_i_q);
			pi_q_o  <= sat_out(sum_q_q);
		end
	end

endmodule

// File: design/integ_rail.sv
// One integrator rail; gate and clear are aligned to the proportional sample at the rail input
`timescale 1ns/100ps

module integ_rail (
	input  logic                                   clk,
	input  logic                                   arst_n_i,
	input  logic signed [piloop_pkg::DATA_W-1:0]   sig_i,
	input  logic signed [piloop_pkg::GAIN_W-1:0]   ratio_i,
	input  logic        [piloop_pkg::SHIFT_W-1:0]  shift_i,
	input  logic signed [piloop_pkg::FF_W-1:0]     ff_i,
	input  logic                                   gate_i,
	input  logic                                   clear_i,
	output logic signed [piloop_pkg::ACC_W-1:0]    acc_o
);
	import piloop_pkg::*;

	// Ki/Kp scaling of the proportional term
	logic signed [MUL_W-1:0] mult, mult_sh;
	// Stage 1 product, small enough to fit the accumulator width
	logic signed [ACC_W-1:0] scaled_q;
	logic                    gate_q, clear_q;
	// Stage 2 accumulator
	logic signed [ACC_W-1:0] acc_q;
	// One growth bit on both adders
	logic signed [ACC_W:0]   acc_sum, ff_sh, out_sum;

	// Overflow shows as the top two bits disagreeing
	function automatic logic signed [ACC_W-1:0] sat_acc(input logic signed [ACC_W:0] s);
		if (s[ACC_W] == s[ACC_W-1])
			return s[ACC_W-1:0];
		return {s[ACC_W], {(ACC_W-1){~s[ACC_W]}}};
	endfunction

	assign mult = sig_i * ratio_i;
	// Fixed renormalize plus the run-time down-shift
	assign mult_sh = mult >>> (PROD_SHIFT + shift_i);

	assign acc_sum = (ACC_W+1)'(acc_q) + (ACC_W+1)'(scaled_q);

	// Feedforward enters at the accumulator fraction scale
	assign ff_sh = (ACC_W+1)'(ff_i) <<< INT_DROP;
	assign out_sum = (ACC_W+1)'(acc_q) + ff_sh;
	assign acc_o = sat_acc(out_sum);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			scaled_q <= '0;
			gate_q   <= 1'b0;
			clear_q  <= 1'b0;
			acc_q    <= '0;
		end else begin
			// At most 19 significant bits survive the shift
			scaled_q <= mult_sh[ACC_W-1:0];
			// Controls travel with the sample they were applied to
			gate_q   <= gate_i;
			clear_q  <= clear_i;
			// Clear wins over the gate
			if (clear_q)
				acc_q <= '0;
			else if (gate_q)
				acc_q <= sat_acc(acc_sum);
		end
	end

endmodule

// File: design/cplx_prop_gain.sv
// Clamps the complex error and multiplies it by Kp; three register stages, gated by fb_en_i
`timescale 1ns/100ps

module cplx_prop_gain (
	input  logic                                   clk,
	input  logic                                   arst_n_i,
	input  logic signed [piloop_pkg::ERR_W-1:0]    err_i_i,
	input  logic signed [piloop_pkg::ERR_W-1:0]    err_q_i,
	input  logic signed [piloop_pkg::GAIN_W-1:0]   kp_i_i,
	input  logic signed [piloop_pkg::GAIN_W-1:0]   kp_q_i,
	input  logic                                   fb_en_i,
	output logic signed [piloop_pkg::DATA_W-1:0]   prop_i_o,
	output logic signed [piloop_pkg::DATA_W-1:0]   prop_q_o
);
	import piloop_pkg::*;

	// Stage 1 registers, raw inputs
	logic signed [ERR_W-1:0]  err_i_q, err_q_q;
	logic signed [GAIN_W-1:0] kp_i_q, kp_q_q;
	logic                     fb_en_q;
	// Clamped and scaled error
	logic signed [DATA_W-1:0] err_c_i, err_c_q;
	// Stage 2 registers, the four partial products
	logic signed [MUL_W-1:0]  p_ii, p_qq, p_iq, p_qi;
	logic                     fb_en_qq;
	// Complex sums before renormalizing
	logic signed [CSUM_W-1:0] sum_i, sum_q;

	// Keep the low bits when the top bits agree, else rail to the same-sign extreme
	function automatic logic signed [CLAMP_MSB:0] clamp_err(input logic signed [ERR_W-1:0] e);
		if (&e[ERR_W-1:CLAMP_MSB] || ~|e[ERR_W-1:CLAMP_MSB])
			return e[CLAMP_MSB:0];
		return {e[ERR_W-1], {CLAMP_MSB{~e[ERR_W-1]}}};
	endfunction

	// Arithmetic down-shift, then saturate to the data width
	function automatic logic signed [DATA_W-1:0] sat_prod(input logic signed [CSUM_W-1:0] s);
		logic signed [CSUM_W-1:0] sh;
		sh = s >>> PROD_SHIFT;
		if (&sh[CSUM_W-1:DATA_W-1] || ~|sh[CSUM_W-1:DATA_W-1])
			return sh[DATA_W-1:0];
		return {sh[CSUM_W-1], {(DATA_W-1){~sh[CSUM_W-1]}}};
	endfunction

	// Clamp runs between stage 1 and the multipliers
	assign err_c_i = DATA_W'(clamp_err(err_i_q)) <<< CLAMP_SHIFT;
	assign err_c_q = DATA_W'(clamp_err(err_q_q)) <<< CLAMP_SHIFT;

	// (err_i + j err_q) * (kp_i + j kp_q)
	assign sum_i = CSUM_W'(p_ii) - CSUM_W'(p_qq);
	assign sum_q = CSUM_W'(p_iq) + CSUM_W'(p_qi);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			err_i_q  <= '0;
			err_q_q  <= '0;
			kp_i_q   <= '0;
			kp_q_q   <= '0;
			fb_en_q  <= 1'b0;
			p_ii     <= '0;
			p_qq     <= '0;
			p_iq     <= '0;
			p_qi     <= '0;
			fb_en_qq <= 1'b0;
			prop_i_o <= '0;
			prop_q_o <= '0;
		end else begin
			err_i_q  <= err_i_i;
			err_q_q  <= err_q_i;
			kp_i_q   <= kp_i_i;
			kp_q_q   <= kp_q_i;
			fb_en_q  <= fb_en_i;
			p_ii     <= err_c_i * kp_i_q;
			p_qq     <= err_c_q * kp_q_q;
			p_iq     <= err_c_i * kp_q_q;
			p_qi     <= err_c_q * kp_i_q;
			// Enable follows its own error sample down the pipe
			fb_en_qq <= fb_en_q;
			// Open loop forces the proportional term to zero
			prop_i_o <= fb_en_qq ? sat_prod(sum_i) : '0;
			prop_q_o <= fb_en_qq ? sat_prod(sum_q) : '0;
		end
	end

endmodule

// File: design/piloop_pkg.sv
// Width and constant set for the complex PI loop; all arithmetic is two's complement, one clock
package piloop_pkg;

	// Gain words Kp_I, Kp_Q and Ki/Kp, all signed
	localparam int GAIN_W = 18;

	// Incoming complex error, already setpoint-subtracted
	localparam int ERR_W = 19;

	// Error bit where the clamp starts to rail
	localparam int CLAMP_MSB = 13;

	// Clamped error is scaled up by this many bits
	localparam int CLAMP_SHIFT = 3;

	// Proportional term and loop output width
	localparam int DATA_W = 18;

	// Feedforward input width
	localparam int FF_W = 17;

	// Integrator accumulator width
	localparam int ACC_W = 21;

	// Extra down-shift control on the integrator product
	localparam int SHIFT_W = 4;

	// Renormalizing shift after each multiply
	localparam int PROD_SHIFT = 17;

	// Accumulator fraction bits dropped before the final add
	localparam int INT_DROP = 3;

	// Full product width of an error or data word times a gain
	localparam int MUL_W = DATA_W + GAIN_W;

	// Complex product sum carries one growth bit
	localparam int CSUM_W = MUL_W + 1;

	// Register depth of each block
	localparam int PROP_LAT = 3;
	localparam int INT_LAT = 2;
	localparam int OUT_LAT = 2;

endpackage
